// File: compile.f
+incdir+.
mvuDataPkg.sv
mvuCtrlPkg.sv
mvuStepIf.sv
mvuFeeder.sv
mvuDotLane.sv
mvuDrain.sv
mvuTop.sv
tbMvu.sv

// File: mvuRefModel.svh
// reference model of the matrix-vector unit
// per-lane signed dot products, accumulated over steps and
// truncated to the output width when a last step closes them
`ifndef MVU_REF_MODEL_SVH
`define MVU_REF_MODEL_SVH

typedef logic [`MVU_SIMD-1:0][`MVU_ACT_WIDTH-1:0] actRaw;
typedef logic [`MVU_PE-1:0][`MVU_SIMD-1:0][`MVU_WEIGHT_WIDTH-1:0] weightRaw;
typedef logic [`MVU_PE-1:0][`MVU_ACCU_WIDTH-1:0] resultVec;

longint   modelAccu [`MVU_PE];  // open dot product of each lane
resultVec expQ [$];             // finished results in issue order

// numeric value of one raw activation
function automatic longint actValue(input logic [`MVU_ACT_WIDTH-1:0] raw);
    longint v;
    v = raw;                                             // zero-extended
    if (`MVU_SIGNED_ACT && raw[`MVU_ACT_WIDTH-1]) begin
        v = v - (longint'(1) << `MVU_ACT_WIDTH);         // two's complement value
    end
    return v;
endfunction

// numeric value of one weight, always signed
function automatic longint weightValue(input logic [`MVU_WEIGHT_WIDTH-1:0] raw);
    longint v;
    v = raw;
    if (raw[`MVU_WEIGHT_WIDTH-1]) begin
        v = v - (longint'(1) << `MVU_WEIGHT_WIDTH);
    end
    return v;
endfunction

function automatic longint laneDot(input actRaw act,
                                   input logic [`MVU_SIMD-1:0][`MVU_WEIGHT_WIDTH-1:0] row);
    longint sum;
    sum = 0;
    for (int i = 0; i < `MVU_SIMD; i++) begin
        sum += actValue(act[i]) * weightValue(row[i]);
    end
    return sum;
endfunction

function automatic logic [`MVU_ACCU_WIDTH-1:0] truncResult(input longint v);
    return v[`MVU_ACCU_WIDTH-1:0];  // wrap, low bits only
endfunction

// one accepted step, a last step queues the expected vector
task automatic modelStep(input actRaw act, input weightRaw wm,
                         input logic zeroStep, input logic lastStep);
    resultVec res;
    for (int l = 0; l < `MVU_PE; l++) begin
        if (!zeroStep) begin
            modelAccu[l] += laneDot(act, wm[l]);
        end
        res[l] = truncResult(modelAccu[l]);
    end
    if (lastStep) begin
        expQ.push_back(res);
        for (int l = 0; l < `MVU_PE; l++) begin
            modelAccu[l] = 0;  // next dot product starts fresh
        end
    end
endtask

task automatic modelReset();
    for (int l = 0; l < `MVU_PE; l++) begin
        modelAccu[l] = 0;
    end
    expQ.delete();  // results in flight are lost in the DUT too
endtask

`endif

// File: tbMvu.sv
// testbench of the matrix-vector unit
// LFSR-driven steps on falling edges, results checked against
// the reference model whenever vld follows an enabled edge
`timescale 1ns/1ps
`include "mvuSettings.svh"

module tbMvu;

    `include "mvuRefModel.svh"

    localparam int resetCycles     = 16;
    localparam int maxLen          = 8;    // longest random dot product
    localparam int randProducts    = 30;   // dot products per random test
    localparam int extremeProducts = 6;
    localparam int extremeMaxLen   = 121;  // long enough to wrap the output width
    localparam int resetRounds     = 8;
    localparam int drainLimit      = 8;    // skip steps allowed to flush a test
    localparam int maxSteps = 40 + 3 * randProducts * maxLen
                            + extremeProducts * extremeMaxLen + resetRounds * 18;
    localparam int cycleLimit = 6 * maxSteps + resetCycles + resetRounds * 4
                              + 6 * (drainLimit + 4);

    localparam logic [`MVU_ACT_WIDTH-1:0] actMin =
        `MVU_SIGNED_ACT ? {1'b1, {(`MVU_ACT_WIDTH-1){1'b0}}} : '0;
    localparam logic [`MVU_ACT_WIDTH-1:0] actMax =
        `MVU_SIGNED_ACT ? {1'b0, {(`MVU_ACT_WIDTH-1){1'b1}}} : '1;
    localparam logic [`MVU_WEIGHT_WIDTH-1:0] wMin = {1'b1, {(`MVU_WEIGHT_WIDTH-1){1'b0}}};
    localparam logic [`MVU_WEIGHT_WIDTH-1:0] wMax = {1'b0, {(`MVU_WEIGHT_WIDTH-1){1'b1}}};

    logic     clk;
    logic     rst;
    logic     en;
    logic     last;
    logic     zero;
    actRaw    a;
    weightRaw w;
    logic     vld;
    resultVec p;

    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          testErrors0;   // counts at the start of the running test
    int          testChecks0;
    int          cycleCount;
    int          stallPercent;  // stall chance out of 128, 0 disables
    logic        edgeEnabled;   // the coming rising edge accepts a step
    logic        edgeReset;     // the coming rising edge resets
    logic        lastVld;

    mvuTop i_mvuTop (
        .clk  (clk),
        .rst  (rst),
        .en   (en),
        .last (last),
        .zero (zero),
        .a    (a),
        .w    (w),
        .vld  (vld),
        .p    (p)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount <= cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("=== FAIL ===");
        $finish;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return v;
    endfunction

    task automatic checkOutputs();
        resultVec exp;
        if (edgeReset) begin
            assert (vld === 1'b0) else begin
                $display("MISMATCH at %0t: vld expected 0, got %b", $time, vld);
                errorCount++;
            end
        end else if (!edgeEnabled) begin
            assert (vld === lastVld) else begin  // stall holds the output
                $display("MISMATCH at %0t: vld expected %b, got %b", $time, lastVld, vld);
                errorCount++;
            end
        end else begin
            assert (!$isunknown(vld)) else begin
                $display("ERROR at %0t: vld is unknown after an enabled edge", $time);
                errorCount++;
            end
            if (vld === 1'b1) begin
                assert (expQ.size() > 0) else begin
                    $display("ERROR at %0t: vld raised with no result outstanding", $time);
                    errorCount++;
                end
                if (expQ.size() > 0) begin
                    exp = expQ.pop_front();
                    checkCount++;
                    for (int l = 0; l < `MVU_PE; l++) begin
                        assert (p[l] === exp[l]) else begin
                            $display("MISMATCH at %0t: p[%0d] expected %h, got %h",
                                     $time, l, exp[l], p[l]);
                            errorCount++;
                        end
                    end
                end
            end
        end
        lastVld = vld;
    endtask

    task automatic nextCycle();
        @(negedge clk);
        checkOutputs();  // outputs settled since the last rising edge
    endtask

    task automatic setControls(input logic enVal, input logic rstVal,
                               input logic lastVal, input logic zeroVal);
        en          = enVal;
        rst         = rstVal;
        last        = lastVal;
        zero        = zeroVal;
        edgeEnabled = enVal && !rstVal;
        edgeReset   = rstVal;
    endtask

    // 0 random, 1 both minimum, 2 both maximum, 3 max act by min weight, 4 mixed extremes
    task automatic randomizeData(input int pattern);
        for (int i = 0; i < `MVU_SIMD; i++) begin
            case (pattern)
                0:       a[i] = randBits(`MVU_ACT_WIDTH);
                1:       a[i] = actMin;
                2, 3:    a[i] = actMax;
                default: a[i] = randBits(1) ? actMax : actMin;
            endcase
        end
        for (int l = 0; l < `MVU_PE; l++) begin
            for (int i = 0; i < `MVU_SIMD; i++) begin
                case (pattern)
                    0:       w[l][i] = randBits(`MVU_WEIGHT_WIDTH);
                    1, 3:    w[l][i] = wMin;
                    2:       w[l][i] = wMax;
                    default: w[l][i] = randBits(1) ? wMax : wMin;
                endcase
            end
        end
    endtask

    // one accepted step, maybe preceded by a stretch of stall cycles
    task automatic issueStep(input logic lastStep, input logic zeroStep, input int pattern);
        int stallLen;
        if (stallPercent > 0 && randBits(7) < stallPercent) begin
            stallLen = 1 + randBits(2);
            repeat (stallLen) begin
                nextCycle();
                setControls(1'b0, 1'b0, randBits(1), randBits(1));  // garbage, must be ignored
                randomizeData(0);
            end
        end
        nextCycle();
        setControls(1'b1, 1'b0, lastStep, zeroStep);
        randomizeData(pattern);
        modelStep(a, w, zeroStep, lastStep);
    endtask

    task automatic applyReset(input int cycles, input bit randomEn);
        repeat (cycles) begin
            nextCycle();
            setControls(randomEn ? randBits(1) : 1'b0, 1'b1, randBits(1), randBits(1));
            randomizeData(0);
            modelReset();
        end
    endtask

    // flush with skip steps, then report the test
    task automatic endTest(input string name);
        int k;
        stallPercent = 0;
        k = 0;
        while (expQ.size() > 0 && k < drainLimit) begin
            issueStep(1'b0, 1'b1, 0);
            k++;
        end
        assert (expQ.size() == 0) else begin
            $display("ERROR: %0d results of test %s never arrived", expQ.size(), name);
            errorCount++;
        end
        expQ.delete();
        repeat (4) issueStep(1'b0, 1'b1, 0);  // a stray vld shows up here
        $display("test %s: %0d results checked, %0d errors", name,
                 checkCount - testChecks0, errorCount - testErrors0);
        testChecks0 = checkCount;
        testErrors0 = errorCount;
    endtask

    initial begin
        int len;
        int pattern;
        lfsrState    = 32'hf7d8;
        errorCount   = 0;
        checkCount   = 0;
        testErrors0  = 0;
        testChecks0  = 0;
        stallPercent = 0;
        lastVld      = 1'b0;
        a            = '0;
        w            = '0;
        setControls(1'b0, 1'b1, 1'b0, 1'b0);
        modelReset();
        applyReset(resetCycles - 1, 1'b0);  // first reset cycle driven at time zero

        repeat (40) issueStep(1'b1, 1'b0, 0);
        endTest("single-step products");

        repeat (randProducts) begin
            len = 1 + randBits(3);
            for (int s = 0; s < len; s++) begin
                issueStep(s == len - 1, 1'b0, 0);
            end
        end
        endTest("multi-step accumulation");

        repeat (randProducts) begin
            len = 1 + randBits(3);
            for (int s = 0; s < len; s++) begin
                issueStep(s == len - 1, randBits(2) == 0, 0);  // last step may be zero too
            end
        end
        endTest("zero steps");

        stallPercent = 40;
        repeat (randProducts) begin
            len = 1 + randBits(3);
            for (int s = 0; s < len; s++) begin
                issueStep(s == len - 1, randBits(3) == 0, 0);
            end
        end
        endTest("stalls");

        repeat (extremeProducts) begin
            len     = 90 + randBits(5);
            pattern = 1 + randBits(2);   // same corner for the whole product
            for (int s = 0; s < len; s++) begin
                issueStep(s == len - 1, 1'b0, pattern);
            end
        end
        endTest("extreme values");

        repeat (resetRounds) begin
            len = 3 + randBits(3);
            for (int s = 0; s < len; s++) begin
                issueStep(randBits(2) == 0, randBits(3) == 0, 0);  // leaves work in flight
            end
            applyReset(1 + randBits(2), 1'b1);
            len = 1 + randBits(3);
            for (int s = 0; s < len; s++) begin
                issueStep(s == len - 1, 1'b0, 0);
            end
        end
        endTest("reset mid-stream");

        $display("total: %0d results checked, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: mvuTop.sv
// matrix-vector multiply unit, top level
// feeder, one dot-product lane per output row and the result drain
`timescale 1ns/1ps
`include "mvuSettings.svh"

module mvuTop
    import mvuDataPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic en,      // global step enable
    input  logic last,
    input  logic zero,
    input  logic [`MVU_SIMD-1:0][`MVU_ACT_WIDTH-1:0] a,
    input  logic [`MVU_PE-1:0][`MVU_SIMD-1:0][`MVU_WEIGHT_WIDTH-1:0] w,
    output logic vld,
    output logic [`MVU_PE-1:0][`MVU_ACCU_WIDTH-1:0] p
);

    weightMatrix        wReg;      // weights aligned with the step bus
    sumVec              totals;    // lane results
    logic [`MVU_PE-1:0] laneDone;  // only lane 0 is used, all run in lockstep

    mvuStepIf stepBus (.advance(en));  // en stalls every stage

    mvuFeeder i_mvuFeeder (
        .clk  (clk),
        .rst  (rst),
        .en   (en),
        .last (last),
        .zero (zero),
        .a    (a),
        .w    (w),
        .step (stepBus.feeder),
        .wReg (wReg)
    );

    for (genvar i = 0; i < `MVU_PE; i++) begin : genLane
        mvuDotLane i_mvuDotLane (
            .clk   (clk),
            .rst   (rst),
            .step  (stepBus.lane),
            .w     (wReg[i]),
            .done  (laneDone[i]),
            .total (totals[i])
        );
    end

    mvuDrain i_mvuDrain (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .done   (laneDone[0]),
        .totals (totals),
        .vld    (vld),
        .p      (p)
    );

endmodule

// File: mvuDrain.sv
// result drain of the matrix-vector unit
// captures the lane totals, truncates them to the output width and
// raises vld for one enabled edge per finished dot product
`timescale 1ns/1ps
`include "mvuSettings.svh"

module mvuDrain
    import mvuDataPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   en,       // stall holds vld and p
    input  logic   done,     // from lane 0, lanes run in lockstep
    input  sumVec  totals,   // full-width lane totals
    output logic   vld,
    output accuVec p         // truncated results
);

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= 1'b0;
            p   <= '0;
        end else if (en) begin
            vld <= done;     // stays high through a following stall
            if (done) begin
                for (int i = 0; i < `MVU_PE; i++) begin
                    p[i] <= totals[i][`MVU_ACCU_WIDTH-1:0];  // wrap to output width
                end
            end
            // p keeps the previous result otherwise
        end
    end

endmodule

// File: mvuDotLane.sv
// dot-product lane of the matrix-vector unit
// multiplies one weight row by the shared activations, reduces the
// products with an adder tree and accumulates until a last step
`timescale 1ns/1ps
`include "mvuSettings.svh"

module mvuDotLane
    import mvuDataPkg::*, mvuCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    mvuStepIf.lane   step,
    input  weightRow w,       // this lane's row, registered with the step
    output logic     done,    // total valid for this enabled edge
    output sumWord   total    // finished dot product
);

    localparam int levels = $clog2(`MVU_SIMD);  // adder tree depth
    localparam int leaves = 1 << levels;        // tree inputs padded to a power of two

    stageCtrl ctrl1;    // after product stage
    stageCtrl ctrl2;    // after adder-tree stage
    prodVec   prod;     // registered products
    sumWord   sum2;     // registered tree sum
    sumWord   accu;     // running accumulator
    sumWord   accuNext;
    sumWord   tree [levels+1][leaves];
    sumWord   treeSum;

    // pairwise reduction with unused leaves held at zero
    always_comb begin
        tree = '{default: '0};
        for (int i = 0; i < `MVU_SIMD; i++) begin
            tree[0][i] = $signed(prod[i]);           // sign-extend to accumulator width
        end
        for (int l = 0; l < levels; l++) begin
            for (int n = 0; n < (leaves >> (l + 1)); n++) begin
                tree[l+1][n] = tree[l][2*n] + tree[l][2*n+1];
            end
        end
    end

    assign treeSum  = tree[levels][0];
    assign accuNext = accu + sum2;

    // stage control, accumulator and done flag
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl1 <= '{valid: 1'b0, op: OP_SKIP};
            ctrl2 <= '{valid: 1'b0, op: OP_SKIP};
            accu  <= '0;
            done  <= 1'b0;
        end else if (step.advance) begin
            ctrl1 <= '{valid: step.stepValid, op: step.op};
            ctrl2 <= ctrl1;
            done  <= ctrl2.valid && opIsLast(ctrl2.op);  // one enabled edge per result
            if (ctrl2.valid) begin
                // restart from zero after a finished dot product
                accu <= opIsLast(ctrl2.op) ? '0 : accuNext;
            end
        end
    end

    // data path registers
    always_ff @(posedge clk) begin
        if (step.advance) begin
            for (int i = 0; i < `MVU_SIMD; i++) begin
                if (opIsSkip(step.op)) begin
                    prod[i] <= '0;  // skip steps contribute nothing
                end else begin
                    prod[i] <= $signed(step.act[i]) * $signed(w[i]);
                end
            end
            sum2 <= treeSum;
            if (ctrl2.valid && opIsLast(ctrl2.op)) begin
                total <= accuNext;  // includes this step's sum
            end
        end
    end

endmodule

// File: mvuFeeder.sv
// step feeder of the matrix-vector unit
// extends activations, encodes zero/last into an opcode and
// registers the step and the weight matrix for the lanes
`timescale 1ns/1ps
`include "mvuSettings.svh"

module mvuFeeder
    import mvuDataPkg::*, mvuCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        en,     // step accepted on every enabled edge
    input  logic        last,   // step closes the dot product
    input  logic        zero,   // step contributes nothing
    input  actRawVec    a,      // raw activations
    input  weightMatrix w,      // one weight row per lane
    mvuStepIf.feeder    step,
    output weightMatrix wReg    // weights aligned with the step on the bus
);

    localparam bit signedAct = `MVU_SIGNED_ACT;

    actVec actExt;  // activations widened by one bit
    stepOp opNext;  // encoded flags of the incoming step

    // sign or zero extension, chosen at build time
    always_comb begin
        for (int i = 0; i < `MVU_SIMD; i++) begin
            actExt[i] = {signedAct && a[i][`MVU_ACT_WIDTH-1], a[i]};
        end
    end

    // raw flags are tested here only, lanes see the opcode
    assign opNext = encodeOp(zero, last);

    // control half of the step register
    always_ff @(posedge clk) begin
        if (rst) begin
            step.stepValid <= 1'b0;
            step.op        <= OP_SKIP;   // harmless idle opcode
        end else if (en) begin
            step.stepValid <= 1'b1;      // every enabled edge carries a step
            step.op        <= opNext;
        end
    end

    // payload half, qualified by stepValid downstream
    always_ff @(posedge clk) begin
        if (en) begin
            step.act <= actExt;
            wReg     <= w;               // weights travel with their step
        end
    end

endmodule

// File: mvuStepIf.sv
// step bus from the feeder to every dot-product lane
// carries one encoded step plus the global advance (stall) control
`timescale 1ns/1ps

interface mvuStepIf
    import mvuDataPkg::*, mvuCtrlPkg::*;
(
    input logic advance  // global step enable, low stalls every stage
);

    logic  stepValid;    // a step is present on the bus
    stepOp op;           // encoded zero/last
    actVec act;          // extended activations, shared by all lanes

    // feeder drives the step, advance comes from the top level
    modport feeder (
        output stepValid,
        output op,
        output act
    );

    // lanes only listen
    modport lane (
        input stepValid,
        input op,
        input act,
        input advance
    );

endinterface

// File: mvuCtrlPkg.sv
// matrix-vector unit control types
// step opcode and per-stage control word of the lane pipeline
package mvuCtrlPkg;

    // bit 1 marks a skipped step, bit 0 closes the dot product
    typedef enum logic [1:0] {
        OP_MAC       = 2'b00,  // add the products
        OP_MAC_LAST  = 2'b01,  // add the products and finish
        OP_SKIP      = 2'b10,  // add zero
        OP_SKIP_LAST = 2'b11   // add zero and finish
    } stepOp;

    typedef struct packed {
        logic  valid;   // stage holds a real step
        stepOp op;
    } stageCtrl;

    function automatic stepOp encodeOp(input logic zero, input logic last);
        return stepOp'({zero, last});
    endfunction

    function automatic logic opIsLast(input stepOp op);
        return (op == OP_MAC_LAST) || (op == OP_SKIP_LAST);
    endfunction

    function automatic logic opIsSkip(input stepOp op);
        return (op == OP_SKIP) || (op == OP_SKIP_LAST);
    endfunction

endpackage

// File: mvuDataPkg.sv
// matrix-vector unit data types
// activations, weight rows, products and accumulator words
`include "mvuSettings.svh"

package mvuDataPkg;

    // raw activation vector as it arrives at the top level
    typedef logic [`MVU_SIMD-1:0][`MVU_ACT_WIDTH-1:0] actRawVec;

    // one extra bit lets signed and unsigned activations share a signed multiply
    typedef logic signed [`MVU_ACT_WIDTH:0] actElem;
    typedef actElem [`MVU_SIMD-1:0] actVec;

    typedef logic signed [`MVU_WEIGHT_WIDTH-1:0] weightElem;
    typedef weightElem [`MVU_SIMD-1:0] weightRow;        // one lane's weights
    typedef weightRow [`MVU_PE-1:0] weightMatrix;        // all lanes

    // full-precision product of an extended activation and a weight
    typedef logic signed [`MVU_ACT_WIDTH+`MVU_WEIGHT_WIDTH:0] prodWord;
    typedef prodWord [`MVU_SIMD-1:0] prodVec;

    typedef logic signed [`MVU_SUM_WIDTH-1:0] sumWord;  // lane accumulator
    typedef sumWord [`MVU_PE-1:0] sumVec;               // totals of all lanes

    typedef logic [`MVU_ACCU_WIDTH-1:0] accuWord;        // truncated output result
    typedef accuWord [`MVU_PE-1:0] accuVec;

endpackage

// File: mvuSettings.svh
// matrix-vector unit build settings
// lane count, vector length, data widths and activation signedness
`ifndef MVU_SETTINGS_SVH
`define MVU_SETTINGS_SVH

// array shape
`define MVU_PE 4            // processing lanes, one matrix row each
`define MVU_SIMD 6          // elements per vector step

// operand widths
`define MVU_ACT_WIDTH 4     // raw activation bits
`define MVU_WEIGHT_WIDTH 4  // signed weight bits

// result widths
`define MVU_ACCU_WIDTH 16   // output width, results wrap here
`define MVU_SUM_WIDTH 24    // internal accumulator, wide enough for any test run

// 1 selects signed activations, 0 unsigned
`define MVU_SIGNED_ACT 1

`endif
